/* bench/antic_dlist_assert.sv */
`timescale 1ns/1ns
`include "antic_defines.svh"

module antic_dlist_assert (
    input logic               clock,
    input logic               rst,
    input logic               byte_req,
    input logic               byte_valid,
    input logic               instr_valid,
    input logic               busy,
    input logic [`DATA_W-1:0] instr,
    input logic               line_strobe,
    input logic               running,
    input logic               frame_done
);

    // Fetch answers each request one cycle later
    a_byte_valid: assert property (@(posedge clock) disable iff (rst)
        byte_req |=> byte_valid) else $error("byte_valid missing after byte_req");

    a_byte_only: assert property (@(posedge clock) disable iff (rst)
        byte_valid |-> $past(byte_req)) else $error("byte_valid without byte_req");

    // Offered instruction held until the sequencer is free
    a_instr_hold: assert property (@(posedge clock) disable iff (rst)
        (instr_valid && busy) |=> (instr_valid && $stable(instr)))
        else $error("instr changed while busy");

    a_strobe_run: assert property (@(posedge clock) disable iff (rst)
        $rose(line_strobe) |-> running) else $error("line_strobe while not running");

    a_frame_pulse: assert property (@(posedge clock) disable iff (rst)
        frame_done |=> !frame_done) else $error("frame_done longer than one cycle");

endmodule

// Sees both stage interfaces from the top level
bind antic_dlist_top antic_dlist_assert antic_dlist_assert_i (
    .clock      (clock),
    .rst        (rst),
    .byte_req   (fetch_bus.byte_req),
    .byte_valid (fetch_bus.byte_valid),
    .instr_valid(instr_bus.instr_valid),
    .busy       (instr_bus.busy),
    .instr      (instr_bus.instr),
    .line_strobe(line_strobe),
    .running    (running),
    .frame_done (frame_done)
);

/* bench/antic_dlist_tb.sv */
`timescale 1ns/1ns
`include "antic_defines.svh"

module antic_dlist_tb;

    logic               clock;
    logic               rst;
    logic               wr_en;
    logic [`ADDR_W-1:0] wr_addr;
    logic [`DATA_W-1:0] wr_data;
    logic               start;
    logic [`ADDR_W-1:0] dlist_addr;
    logic               scan_tick;
    logic               line_strobe;
    logic [3:0]         line_mode;
    logic [`ADDR_W-1:0] line_addr;
    logic [3:0]         line_row;
    logic               line_dli;
    logic               frame_done;
    logic               running;

    logic [`ADDR_W-1:0] load_addr_q[$];  // Host writes from the golden file
    logic [`DATA_W-1:0] load_data_q[$];
    logic [24:0]        exp_q[$];        // {mode, addr, row, dli}
    logic [`ADDR_W-1:0] start_addr;
    logic [24:0]        rec;

    integer seed = 32'hbf67;
    integer rnd;
    integer mismatches = 0;
    integer failures   = 0;  // Protocol, file and timeout problems
    integer timeout_cycles;
    logic   loaded     = 1'b0;
    logic   frame_seen = 1'b0;

    antic_dlist_top antic_dlist_top_i (.*);

    initial clock = 1'b0;
    always #4 clock = ~clock;  // 8 ns period

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            mismatches = mismatches + 1;
            $display("ERR %s got %0h expected %0h at %0t", name, actual, expected, $time);
        end
    endtask

    // Letter tags start records, # starts a comment line
    task automatic read_golden;
        integer     fd;
        integer     c;
        integer     n;
        integer     a;
        integer     d;
        integer     m;
        integer     r;
        logic [7:0] ch;
        fd = $fopen("bench/dlist_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/dlist_golden.txt");
            failures = failures + 1;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                ch = c[7:0];
                if (ch == "#") begin
                    while (c != -1 && c[7:0] != "\n")
                        c = $fgetc(fd);
                end else if (ch == "W") begin
                    n = $fscanf(fd, " %h %h", a, d);
                    load_addr_q.push_back(a[15:0]);
                    load_data_q.push_back(d[7:0]);
                end else if (ch == "S") begin
                    n = $fscanf(fd, " %h", a);
                    start_addr = a[15:0];
                end else if (ch == "E") begin
                    n = $fscanf(fd, " %h %h %h %h", m, a, r, d);
                    if (n != 4) begin
                        $display("golden file has a broken line record");
                        failures = failures + 1;
                    end
                    exp_q.push_back({m[3:0], a[15:0], r[3:0], d[0]});
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // Compare one emitted line record with the next expected one
    task automatic sample_outputs;
        if (frame_done)
            frame_seen = 1'b1;
        if (line_strobe) begin
            if (exp_q.size() == 0) begin
                $display("line record at %0t goes past the expected list", $time);
                failures = failures + 1;
            end else begin
                rec = exp_q.pop_front();
                check_value("line_mode", 32'(line_mode), 32'(rec[24:21]));
                check_value("line_addr", 32'(line_addr), 32'(rec[20:5]));
                check_value("line_row",  32'(line_row),  32'(rec[4:1]));
                check_value("line_dli",  32'(line_dli),  32'(rec[0]));
            end
        end
    endtask

    task automatic finish_run;
        $display("errors: %0d (%0d value mismatches, %0d other)",
                 mismatches + failures, mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    endtask

    initial begin
        rst        = 1'b1;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        start      = 1'b0;
        dlist_addr = '0;
        scan_tick  = 1'b0;
        start_addr = '0;
        read_golden();
        timeout_cycles = 64 * exp_q.size() + load_addr_q.size() + 100;
        loaded = 1'b1;
        if (failures == 0) begin
            repeat (5) @(posedge clock);
            @(negedge clock);
            rst = 1'b0;
            foreach (load_addr_q[i]) begin  // One host write per cycle
                wr_en   = 1'b1;
                wr_addr = load_addr_q[i];
                wr_data = load_data_q[i];
                @(negedge clock);
            end
            wr_en      = 1'b0;
            start      = 1'b1;
            dlist_addr = start_addr;
            @(negedge clock);
            start = 1'b0;
            check_value("running", 32'(running), 32'd1);
            while (!frame_seen) begin
                sample_outputs();
                rnd       = $random(seed);
                scan_tick = rnd[0];  // Tick half the time
                @(negedge clock);
            end
            if (exp_q.size() != 0) begin
                $display("frame ended with %0d line records still missing", exp_q.size());
                failures = failures + 1;
            end
            repeat (40) begin  // Ticks keep coming after JVB
                if (line_strobe) begin
                    $display("line_strobe seen after frame_done at %0t", $time);
                    failures = failures + 1;
                end
                rnd       = $random(seed);
                scan_tick = rnd[0];
                @(negedge clock);
            end
            check_value("running", 32'(running), 32'd0);
        end
        finish_run();
    end

    // 64 cycles per expected record plus load time
    initial begin
        wait (loaded);
        repeat (timeout_cycles) @(posedge clock);
        $display("timeout after %0d cycles, frame_done never arrived", timeout_cycles);
        failures = failures + 1;
        finish_run();
    end

endmodule

/* bench/dlist_golden.txt */
# W addr data = host write, S addr = start, E mode addr row dli = expected line record
# All values hex, E records in emission order
# Three blank-8 lines, then LMS mode 2 at 2000
W 1000 70  W 1001 70  W 1002 70
W 1003 42  W 1004 00  W 1005 20
# Mode 2, mode 3, mode 8
W 1006 02  W 1007 03  W 1008 08
# Plain jump to 1100, the byte after it is never fetched
W 1009 01  W 100a 00  W 100b 11  W 100c 0f
# Mode D, mode F with DLI, mode 2 with DLI, blank-8 with DLI
W 1100 0d  W 1101 8f  W 1102 82  W 1103 f0
# JVB back to 1000
W 1104 41  W 1105 00  W 1106 10
S 1000
E 0 0000 0 0  E 0 0000 1 0  E 0 0000 2 0  E 0 0000 3 0
E 0 0000 4 0  E 0 0000 5 0  E 0 0000 6 0  E 0 0000 7 0
E 0 0000 0 0  E 0 0000 1 0  E 0 0000 2 0  E 0 0000 3 0
E 0 0000 4 0  E 0 0000 5 0  E 0 0000 6 0  E 0 0000 7 0
E 0 0000 0 0  E 0 0000 1 0  E 0 0000 2 0  E 0 0000 3 0
E 0 0000 4 0  E 0 0000 5 0  E 0 0000 6 0  E 0 0000 7 0
E 2 2000 0 0  E 2 2000 1 0  E 2 2000 2 0  E 2 2000 3 0
E 2 2000 4 0  E 2 2000 5 0  E 2 2000 6 0  E 2 2000 7 0
E 2 2028 0 0  E 2 2028 1 0  E 2 2028 2 0  E 2 2028 3 0
E 2 2028 4 0  E 2 2028 5 0  E 2 2028 6 0  E 2 2028 7 0
E 3 2050 0 0  E 3 2050 1 0  E 3 2050 2 0  E 3 2050 3 0
E 3 2050 4 0  E 3 2050 5 0  E 3 2050 6 0  E 3 2050 7 0
E 3 2050 8 0  E 3 2050 9 0
E 8 2078 0 0  E 8 2078 1 0  E 8 2078 2 0  E 8 2078 3 0
E 8 2078 4 0  E 8 2078 5 0  E 8 2078 6 0  E 8 2078 7 0
E d 2082 0 0  E d 2082 1 0
E f 20aa 0 1
E 2 20d2 0 0  E 2 20d2 1 0  E 2 20d2 2 0  E 2 20d2 3 0
E 2 20d2 4 0  E 2 20d2 5 0  E 2 20d2 6 0  E 2 20d2 7 1
E 0 20fa 0 0  E 0 20fa 1 0  E 0 20fa 2 0  E 0 20fa 3 0
E 0 20fa 4 0  E 0 20fa 5 0  E 0 20fa 6 0  E 0 20fa 7 1

/* build.f */
+incdir+rtl
rtl/antic_pkg.sv
rtl/antic_if.sv
rtl/display_ram.sv
rtl/dl_fetch.sv
rtl/dl_decode.sv
rtl/line_sequencer.sv
rtl/antic_dlist_top.sv
bench/antic_dlist_assert.sv
bench/antic_dlist_tb.sv

/* rtl/antic_defines.svh */
`ifndef ANTIC_DEFINES_SVH
`define ANTIC_DEFINES_SVH

// Memory bus widths

// Display list pointer and screen address width
`define ADDR_W 16

// One RAM word, one display list byte
`define DATA_W 8

// Full 64K address space
`define RAM_DEPTH 65536

`endif

/* rtl/antic_dlist_top.sv */
`timescale 1ns/1ns
`include "antic_defines.svh"

module antic_dlist_top (
    input  logic               clock,
    input  logic               rst,
    input  logic               wr_en,
    input  logic [`ADDR_W-1:0] wr_addr,
    input  logic [`DATA_W-1:0] wr_data,
    input  logic               start,
    input  logic [`ADDR_W-1:0] dlist_addr,
    input  logic               scan_tick,
    output logic               line_strobe,
    output logic [3:0]         line_mode,
    output logic [`ADDR_W-1:0] line_addr,
    output logic [3:0]         line_row,
    output logic               line_dli,
    output logic               frame_done,
    output logic               running
);

    logic               rd_en;    // Fetch to RAM
    logic [`ADDR_W-1:0] rd_addr;
    logic [`DATA_W-1:0] rd_data;

    dl_fetch_if fetch_bus ();     // Decode and fetch
    dl_instr_if instr_bus ();     // Decode and sequencer

    display_ram display_ram_i (
        .clock  (clock),
        .rst    (rst),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_en  (rd_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    dl_fetch dl_fetch_i (
        .clock     (clock),
        .rst       (rst),
        .start     (start),
        .dlist_addr(dlist_addr),
        .frame_done(frame_done),  // Clears running after JVB
        .running   (running),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .fetch     (fetch_bus.fetch)
    );

    dl_decode dl_decode_i (
        .clock  (clock),
        .rst    (rst),
        .running(running),
        .dec    (fetch_bus.dec),
        .src    (instr_bus.src)
    );

    line_sequencer line_sequencer_i (
        .clock      (clock),
        .rst        (rst),
        .scan_tick  (scan_tick),
        .snk        (instr_bus.snk),
        .line_strobe(line_strobe),
        .line_mode  (line_mode),
        .line_addr  (line_addr),
        .line_row   (line_row),
        .line_dli   (line_dli),
        .frame_done (frame_done)
    );

endmodule

/* rtl/antic_if.sv */
`timescale 1ns/1ns
`include "antic_defines.svh"

// Decode asks for display list bytes, fetch returns them
interface dl_fetch_if;
    logic                byte_req;    // One cycle pulse
    logic                byte_valid;  // Exactly one cycle after byte_req
    logic [`DATA_W-1:0]  byte_data;
    logic                jump_load;   // Pointer reload at next edge
    logic [`ADDR_W-1:0]  jump_addr;

    modport dec (
        output byte_req, jump_load, jump_addr,
        input  byte_valid, byte_data
    );

    modport fetch (
        input  byte_req, jump_load, jump_addr,
        output byte_valid, byte_data
    );
endinterface

// Decoded instruction handed to the scanline sequencer
interface dl_instr_if;
    logic                  instr_valid;  // Held until taken
    antic_pkg::dl_instr_u  instr;
    logic [`ADDR_W-1:0]    lms_addr;     // Valid with LMS only
    logic                  busy;         // Sequencer still emitting lines

    modport src (
        output instr_valid, instr, lms_addr,
        input  busy
    );

    modport snk (
        input  instr_valid, instr, lms_addr,
        output busy
    );
endinterface

/* rtl/antic_pkg.sv */
package antic_pkg;

    // Blank line view, mode field reads zero
    typedef struct packed {
        logic       dli;      // Interrupt on last line
        logic [2:0] count;    // Blank lines minus one
        logic [3:0] mode;
    } dl_blank_t;

    // Mode line and jump view
    typedef struct packed {
        logic       dli;
        logic       lms;      // LMS, or JVB when mode is jump
        logic       vscroll;  // Decoded, not used
        logic       hscroll;  // Decoded, not used
        logic [3:0] mode;
    } dl_mode_t;

    // One display list byte, two decodings
    typedef union packed {
        dl_blank_t blank_s;
        dl_mode_t  mode_s;
    } dl_instr_u;

    localparam logic [3:0] OP_BLANK = 4'h0;
    localparam logic [3:0] OP_JUMP  = 4'h1;

    // Scanlines per mode line
    function automatic logic [4:0] mode_rows(input logic [3:0] mode);
        case (mode)
            4'h2, 4'h4, 4'h6, 4'h8: mode_rows = 5'd8;
            4'h3:                   mode_rows = 5'd10;
            4'h5, 4'h7:             mode_rows = 5'd16;
            4'h9, 4'hA:             mode_rows = 5'd4;
            4'hB, 4'hD:             mode_rows = 5'd2;
            default:                mode_rows = 5'd1;  // C, E, F
        endcase
    endfunction

    // Screen bytes per mode line
    function automatic logic [5:0] mode_bytes(input logic [3:0] mode);
        case (mode)
            4'h2, 4'h3, 4'h4, 4'h5, 4'hD, 4'hE, 4'hF: mode_bytes = 6'd40;
            4'h6, 4'h7, 4'hA, 4'hB, 4'hC:             mode_bytes = 6'd20;
            4'h8, 4'h9:                               mode_bytes = 6'd10;
            default:                                  mode_bytes = 6'd0;
        endcase
    endfunction

endpackage

/* rtl/display_ram.sv */
`timescale 1ns/1ns
`include "antic_defines.svh"

module display_ram (
    input  logic               clock,
    input  logic               rst,
    input  logic               wr_en,
    input  logic [`ADDR_W-1:0] wr_addr,
    input  logic [`DATA_W-1:0] wr_data,
    input  logic               rd_en,
    input  logic [`ADDR_W-1:0] rd_addr,
    output logic [`DATA_W-1:0] rd_data
);

    logic [`DATA_W-1:0] mem [0:`RAM_DEPTH-1];  // Display list and screen data

    // Host load port
    always_ff @(posedge clock) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Registered read, data one cycle after rd_en
    always_ff @(posedge clock) begin
        if (rst)
            rd_data <= '0;
        else if (rd_en)
            rd_data <= mem[rd_addr];  // Old data on same-address write
    end

endmodule

/* rtl/dl_decode.sv */
`timescale 1ns/1ns
`include "antic_defines.svh"

module dl_decode (
    input  logic    clock,
    input  logic    rst,
    input  logic    running,
    dl_fetch_if.dec dec,
    dl_instr_if.src src
);

    localparam logic [2:0] S_IDLE    = 3'd0;  // Wait for running
    localparam logic [2:0] S_INSTR   = 3'd1;  // Instruction byte pending
    localparam logic [2:0] S_LO      = 3'd2;  // Operand low byte pending
    localparam logic [2:0] S_HI      = 3'd3;  // Operand high byte pending
    localparam logic [2:0] S_PRESENT = 3'd4;  // Offered to sequencer
    localparam logic [2:0] S_STOP    = 3'd5;  // After JVB

    logic [2:0]           state;
    antic_pkg::dl_instr_u instr_q;
    antic_pkg::dl_instr_u new_instr;
    logic [`ADDR_W-1:0]   opnd_q;  // Assembled jump or LMS address
    logic                 req_q;
    logic                 load_q;
    logic                 valid_q;
    logic                 needs_opnd;
    logic                 is_jump;
    logic                 is_jvb;

    assign new_instr = dec.byte_data;

    // Two operand bytes follow a jump or an LMS mode line
    assign needs_opnd = (new_instr.mode_s.mode == antic_pkg::OP_JUMP) ||
                        ((new_instr.mode_s.mode != antic_pkg::OP_BLANK) &&
                         new_instr.mode_s.lms);
    assign is_jump = instr_q.mode_s.mode == antic_pkg::OP_JUMP;
    assign is_jvb  = is_jump && instr_q.mode_s.lms;  // Bit 6 on a jump

    assign dec.byte_req  = req_q;
    assign dec.jump_load = load_q;
    assign dec.jump_addr = opnd_q;
    assign src.instr_valid = valid_q;
    assign src.instr       = instr_q;
    assign src.lms_addr    = opnd_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            state   <= S_IDLE;
            req_q   <= 1'b0;
            load_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            req_q  <= 1'b0;  // Both are single pulses
            load_q <= 1'b0;
            case (state)
                S_IDLE: if (running) begin
                    req_q <= 1'b1;
                    state <= S_INSTR;
                end
                S_INSTR: if (dec.byte_valid) begin
                    instr_q <= new_instr;
                    if (needs_opnd) begin
                        req_q <= 1'b1;
                        state <= S_LO;
                    end else begin
                        valid_q <= 1'b1;  // Blank or plain mode line
                        state   <= S_PRESENT;
                    end
                end
                S_LO: if (dec.byte_valid) begin
                    opnd_q[`DATA_W-1:0] <= dec.byte_data;
                    req_q               <= 1'b1;
                    state               <= S_HI;
                end
                S_HI: if (dec.byte_valid) begin
                    opnd_q[`ADDR_W-1:`DATA_W] <= dec.byte_data;
                    if (is_jump && !is_jvb) begin
                        load_q <= 1'b1;  // Plain jump, refetch from target
                        state  <= S_IDLE;
                    end else begin
                        valid_q <= 1'b1;
                        state   <= S_PRESENT;
                    end
                end
                S_PRESENT: if (!src.busy) begin
                    valid_q <= 1'b0;  // Taken this cycle
                    if (is_jvb) begin
                        state <= S_STOP;
                    end else begin
                        req_q <= 1'b1;  // Run one instruction ahead
                        state <= S_INSTR;
                    end
                end
                S_STOP: if (!running)
                    state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* rtl/dl_fetch.sv */
`timescale 1ns/1ns
`include "antic_defines.svh"

module dl_fetch (
    input  logic               clock,
    input  logic               rst,
    input  logic               start,
    input  logic [`ADDR_W-1:0] dlist_addr,
    input  logic               frame_done,  // From sequencer, JVB taken
    output logic               running,
    output logic               rd_en,
    output logic [`ADDR_W-1:0] rd_addr,
    input  logic [`DATA_W-1:0] rd_data,
    dl_fetch_if.fetch          fetch
);

    logic [`ADDR_W-1:0] ptr;      // Display list pointer
    logic               valid_q;  // Read in flight

    // Each request is one RAM read at the pointer
    assign rd_en   = fetch.byte_req;
    assign rd_addr = ptr;

    assign fetch.byte_valid = valid_q;
    assign fetch.byte_data  = rd_data;  // RAM output already registered

    always_ff @(posedge clock) begin
        if (rst) begin
            ptr     <= '0;
            running <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch.byte_req;  // RAM latency is one cycle

            // Pointer source priority
            if (start)
                ptr <= dlist_addr;
            else if (fetch.jump_load)
                ptr <= fetch.jump_addr;
            else if (fetch.byte_req)
                ptr <= ptr + 1'b1;  // Step past the byte just read

            // Frame run flag
            if (start)
                running <= 1'b1;
            else if (frame_done)
                running <= 1'b0;  // JVB reached the sequencer
        end
    end

endmodule

/* rtl/line_sequencer.sv */
`timescale 1ns/1ns
`include "antic_defines.svh"

module line_sequencer (
    input  logic               clock,
    input  logic               rst,
    input  logic               scan_tick,
    dl_instr_if.snk            snk,
    output logic               line_strobe,
    output logic [3:0]         line_mode,
    output logic [`ADDR_W-1:0] line_addr,
    output logic [3:0]         line_row,
    output logic               line_dli,
    output logic               frame_done
);

    antic_pkg::dl_instr_u cur;        // Instruction being emitted
    logic                 busy_q;
    logic [4:0]           rows_left;  // Scanlines still to emit
    logic [3:0]           row;
    logic [`ADDR_W-1:0]   scr_addr;   // Screen memory scan counter
    logic                 accept;
    logic                 last_line;
    logic                 is_blank;
    logic                 new_blank;
    logic                 new_jump;

    assign snk.busy  = busy_q;
    assign accept    = snk.instr_valid && !busy_q;
    assign last_line = rows_left == 5'd1;
    assign is_blank  = cur.mode_s.mode == antic_pkg::OP_BLANK;
    assign new_blank = snk.instr.mode_s.mode == antic_pkg::OP_BLANK;
    assign new_jump  = snk.instr.mode_s.mode == antic_pkg::OP_JUMP;  // Only JVB arrives here

    always_ff @(posedge clock) begin
        if (rst) begin
            busy_q      <= 1'b0;
            rows_left   <= '0;
            row         <= '0;
            scr_addr    <= '0;
            line_strobe <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            line_strobe <= 1'b0;
            frame_done  <= 1'b0;
            if (accept) begin
                row <= '0;
                if (new_jump) begin
                    frame_done <= 1'b1;  // End of frame, no lines
                end else begin
                    busy_q <= 1'b1;
                    if (new_blank)
                        rows_left <= 5'(snk.instr.blank_s.count) + 5'd1;
                    else
                        rows_left <= antic_pkg::mode_rows(snk.instr.mode_s.mode);
                    if (!new_blank && snk.instr.mode_s.lms)
                        scr_addr <= snk.lms_addr;  // LMS reload
                end
            end else if (busy_q && scan_tick) begin
                line_strobe <= 1'b1;
                row         <= row + 1'b1;
                rows_left   <= rows_left - 1'b1;
                if (last_line) begin
                    busy_q <= 1'b0;
                    if (!is_blank)  // Next mode line starts after this one's bytes
                        scr_addr <= scr_addr + `ADDR_W'(antic_pkg::mode_bytes(cur.mode_s.mode));
                end
            end
        end
    end

    // Latched instruction and line record
    always_ff @(posedge clock) begin
        if (accept)
            cur <= snk.instr;
        if (!accept && busy_q && scan_tick) begin
            line_mode <= cur.mode_s.mode;  // Zero for blank lines
            line_addr <= scr_addr;
            line_row  <= row;
            line_dli  <= cur.mode_s.dli && last_line;  // DLI on last scanline only
        end
    end

endmodule

/* run_sim.sh */
#!/bin/bash
# Compile with Verilator, run, and grep the output for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -f build.f --top-module antic_dlist_tb -o antic_dlist_sim &&
./obj_dir/antic_dlist_sim | tee /dev/stderr | grep "Testbench passed" > /dev/null &&
echo "simulation: PASS" ||
{ echo "simulation: FAIL"; exit 1; }
